// ==== tests/iq_stim.txt ====
// test dv opc brm tag rd rs1 rs2 p1 p2 wbv wb0 wb1 wb2 wb3 kill, then expected: valid tag opc full
// inputs are driven for the row's cycle, expected values are the outputs seen in that cycle
// 1 idle after reset
01 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
01 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
01 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
// 2 ready at dispatch, issues two cycles after the strobe
02 1 13 0 05 0a 01 02 1 1 0 00 00 00 00 0 0 00 00 0
02 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
02 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 05 13 0
02 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
// 3 wakeup, unrelated reg first, then rs1 and rs2 apart, then same-cycle wakeup
03 1 33 0 07 0b 03 04 0 0 0 00 00 00 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 1 05 00 00 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 2 00 03 00 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 8 00 00 00 04 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 07 33 0
03 1 13 0 08 0c 06 07 1 0 4 00 00 07 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
03 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 08 13 0
03 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
// 4 age order, tag 11 wakes late but still issues ahead of 12 and 13
04 1 03 0 10 01 09 01 0 1 0 00 00 00 00 0 0 00 00 0
04 1 13 0 11 02 0c 01 0 1 0 00 00 00 00 0 0 00 00 0
04 1 23 0 12 03 09 01 0 1 0 00 00 00 00 0 0 00 00 0
04 1 33 0 13 04 09 01 0 1 1 09 00 00 00 0 0 00 00 0
04 0 00 0 00 00 00 00 0 0 2 00 0c 00 00 0 0 00 00 0
04 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 10 03 0
04 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 11 13 0
04 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 12 23 0
04 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 13 33 0
04 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
// 5 branch kill of ready entries, a dispatch under the kill, and kill over grant
05 1 03 1 14 01 0d 02 0 1 0 00 00 00 00 0 0 00 00 0
05 1 13 2 15 02 0d 02 0 1 0 00 00 00 00 0 0 00 00 0
05 1 23 0 16 03 0d 02 0 1 0 00 00 00 00 0 0 00 00 0
05 1 33 3 17 04 0d 02 0 1 0 00 00 00 00 0 0 00 00 0
05 0 00 0 00 00 00 00 0 0 1 0d 00 00 00 0 0 00 00 0
05 1 43 2 18 05 01 02 1 1 0 00 00 00 00 2 0 00 00 0
05 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 14 03 0
05 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 16 23 0
05 1 53 4 19 06 01 02 1 1 0 00 00 00 00 0 0 00 00 0
05 0 00 0 00 00 00 00 0 0 0 00 00 00 00 4 0 00 00 0
05 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
05 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0
// 6 fill to full, ninth dispatch dropped, room again after one issue
06 1 03 0 00 10 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 01 11 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 02 12 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 03 13 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 04 14 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 05 15 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 06 16 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 07 17 0e 01 0 1 0 00 00 00 00 0 0 00 00 0
06 1 03 0 08 18 0e 01 0 1 1 0e 00 00 00 0 0 00 00 1
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 1
06 1 13 0 09 19 01 02 1 1 0 00 00 00 00 0 1 00 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 01 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 02 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 03 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 04 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 05 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 06 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 07 03 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 1 09 13 0
06 0 00 0 00 00 00 00 0 0 0 00 00 00 00 0 0 00 00 0

// ==== tb.f ====
rtl/uop_pkg.sv
rtl/iq_pkg.sv
rtl/issue_slot.sv
rtl/issue_select.sv
rtl/issue_compact.sv
rtl/issue_queue.sv
tests/tb_issue_queue.sv

// ==== tests/tb_issue_queue.sv ====
// self-checking testbench for the issue queue, replays the stim file one row per clock cycle
`timescale 1ns/1ns
`default_nettype none

module tb_issue_queue
	import uop_pkg::*, iq_pkg::*;
();

	localparam int    CLK_PERIOD   = 20;
	localparam int    RST_CYCLES   = 8;
	localparam string STIM_FILE    = "tests/iq_stim.txt";
	localparam int    IDLE_TIMEOUT = 16;

	// one row per cycle, one byte per column
	localparam int COLS     = 20;
	localparam int MAX_ROWS = 128;
	localparam int C_TEST   = 0;
	localparam int C_DV     = 1;
	localparam int C_OPC    = 2;
	localparam int C_BRM    = 3;
	localparam int C_TAG    = 4;
	localparam int C_RD     = 5;
	localparam int C_RS1    = 6;
	localparam int C_RS2    = 7;
	localparam int C_P1     = 8;
	localparam int C_P2     = 9;
	localparam int C_WBV    = 10;
	localparam int C_WB0    = 11;
	localparam int C_KILL   = 15;
	localparam int C_EV     = 16;
	localparam int C_ETAG   = 17;
	localparam int C_EOPC   = 18;
	localparam int C_EFULL  = 19;

	logic                i_clk;
	logic                i_rst;
	logic                i_disp_valid;
	logic [OPC_W-1:0]    i_disp_opcode;
	logic [BR_W-1:0]     i_disp_br_mask;
	logic [TAG_W-1:0]    i_disp_rob_tag;
	logic [PREG_W-1:0]   i_disp_rd;
	logic [PREG_W-1:0]   i_disp_rs1;
	logic [PREG_W-1:0]   i_disp_rs2;
	logic                i_disp_p1;
	logic                i_disp_p2;
	logic [WB_PORTS-1:0] i_wb_valid;
	logic [PREG_W-1:0]   i_wb_preg [WB_PORTS];
	logic [BR_W-1:0]     i_br_kill;

	wire                 o_issue_valid;
	wire  [OPC_W-1:0]    o_issue_opcode;
	wire  [TAG_W-1:0]    o_issue_rob_tag;
	wire  [PREG_W-1:0]   o_issue_rd;
	wire  [PREG_W-1:0]   o_issue_rs1;
	wire  [PREG_W-1:0]   o_issue_rs2;
	wire                 o_full;

	logic [7:0] stim [MAX_ROWS * COLS];
	int         test_errs;
	int         total_errs;
	int         passed;
	int         failed;
	logic       timed_out;

	// register fields of each dispatch, looked up by ROB tag at issue
	logic [PREG_W-1:0] sent_rd  [2**TAG_W];
	logic [PREG_W-1:0] sent_rs1 [2**TAG_W];
	logic [PREG_W-1:0] sent_rs2 [2**TAG_W];

	issue_queue issue_queue_i (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_disp_valid    (i_disp_valid),
		.i_disp_opcode   (i_disp_opcode),
		.i_disp_br_mask  (i_disp_br_mask),
		.i_disp_rob_tag  (i_disp_rob_tag),
		.i_disp_rd       (i_disp_rd),
		.i_disp_rs1      (i_disp_rs1),
		.i_disp_rs2      (i_disp_rs2),
		.i_disp_p1       (i_disp_p1),
		.i_disp_p2       (i_disp_p2),
		.i_wb_valid      (i_wb_valid),
		.i_wb_preg       (i_wb_preg),
		.i_br_kill       (i_br_kill),
		.o_issue_valid   (o_issue_valid),
		.o_issue_opcode  (o_issue_opcode),
		.o_issue_rob_tag (o_issue_rob_tag),
		.o_issue_rd      (o_issue_rd),
		.o_issue_rs1     (o_issue_rs1),
		.o_issue_rs2     (o_issue_rs2),
		.o_full          (o_full)
	);

	initial begin
		i_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) i_clk = ~i_clk;
		end
	end

	function automatic logic [7:0] stim_field(input int r, input int c);
		return stim[r * COLS + c];
	endfunction

	// drive one row of inputs, called right after a rising edge
	task automatic apply_row(input int r);
		i_disp_valid   <= 1'(stim_field(r, C_DV));
		i_disp_opcode  <= OPC_W'(stim_field(r, C_OPC));
		i_disp_br_mask <= BR_W'(stim_field(r, C_BRM));
		i_disp_rob_tag <= TAG_W'(stim_field(r, C_TAG));
		i_disp_rd      <= PREG_W'(stim_field(r, C_RD));
		i_disp_rs1     <= PREG_W'(stim_field(r, C_RS1));
		i_disp_rs2     <= PREG_W'(stim_field(r, C_RS2));
		i_disp_p1      <= 1'(stim_field(r, C_P1));
		i_disp_p2      <= 1'(stim_field(r, C_P2));
		i_wb_valid     <= WB_PORTS'(stim_field(r, C_WBV));
		for (int k = 0; k < WB_PORTS; k++) begin
			i_wb_preg[k] <= PREG_W'(stim_field(r, C_WB0 + k));
		end
		i_br_kill      <= BR_W'(stim_field(r, C_KILL));
		if (stim_field(r, C_DV) != 8'h00) begin
			sent_rd[TAG_W'(stim_field(r, C_TAG))]  = PREG_W'(stim_field(r, C_RD));
			sent_rs1[TAG_W'(stim_field(r, C_TAG))] = PREG_W'(stim_field(r, C_RS1));
			sent_rs2[TAG_W'(stim_field(r, C_TAG))] = PREG_W'(stim_field(r, C_RS2));
		end
	endtask

	// compare the outputs seen during the row's cycle
	task automatic check_row(input int r);
		logic             exp_v;
		logic [TAG_W-1:0] exp_tag;
		logic [OPC_W-1:0] exp_opc;
		logic             exp_full;
		exp_v    = 1'(stim_field(r, C_EV));
		exp_tag  = TAG_W'(stim_field(r, C_ETAG));
		exp_opc  = OPC_W'(stim_field(r, C_EOPC));
		exp_full = 1'(stim_field(r, C_EFULL));
		assert (o_issue_valid === exp_v) else begin
			$display("ERR %0t row %0d o_issue_valid is %b, expected %b",
				$time, r, o_issue_valid, exp_v);
			test_errs++;
		end
		// issue fields only mean something on a valid issue
		if (exp_v) begin
			assert (o_issue_rob_tag === exp_tag) else begin
				$display("ERR %0t row %0d o_issue_rob_tag is %h, expected %h",
					$time, r, o_issue_rob_tag, exp_tag);
				test_errs++;
			end
			assert (o_issue_opcode === exp_opc) else begin
				$display("ERR %0t row %0d o_issue_opcode is %h, expected %h",
					$time, r, o_issue_opcode, exp_opc);
				test_errs++;
			end
			assert (o_issue_rd === sent_rd[exp_tag]) else begin
				$display("ERR %0t row %0d o_issue_rd is %h, expected %h",
					$time, r, o_issue_rd, sent_rd[exp_tag]);
				test_errs++;
			end
			assert (o_issue_rs1 === sent_rs1[exp_tag]) else begin
				$display("ERR %0t row %0d o_issue_rs1 is %h, expected %h",
					$time, r, o_issue_rs1, sent_rs1[exp_tag]);
				test_errs++;
			end
			assert (o_issue_rs2 === sent_rs2[exp_tag]) else begin
				$display("ERR %0t row %0d o_issue_rs2 is %h, expected %h",
					$time, r, o_issue_rs2, sent_rs2[exp_tag]);
				test_errs++;
			end
		end
		assert (o_full === exp_full) else begin
			$display("ERR %0t row %0d o_full is %b, expected %b", $time, r, o_full, exp_full);
			test_errs++;
		end
	endtask

	task automatic report_test(input int num);
		if (test_errs == 0) begin
			$display("test %0d: pass", num);
			passed++;
		end else begin
			$display("test %0d: fail, %0d mismatches", num, test_errs);
			failed++;
		end
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin
		int row;
		int cur_test;
		int waited;
		i_rst          = 1'b1;
		i_disp_valid   = 1'b0;
		i_disp_opcode  = '0;
		i_disp_br_mask = '0;
		i_disp_rob_tag = '0;
		i_disp_rd      = '0;
		i_disp_rs1     = '0;
		i_disp_rs2     = '0;
		i_disp_p1      = 1'b0;
		i_disp_p2      = 1'b0;
		i_wb_valid     = '0;
		for (int k = 0; k < WB_PORTS; k++) begin
			i_wb_preg[k] = '0;
		end
		i_br_kill      = '0;
		test_errs      = 0;
		total_errs     = 0;
		passed         = 0;
		failed         = 0;
		timed_out      = 1'b0;

		// unused rows read as test ff, which ends the replay
		for (int n = 0; n < MAX_ROWS * COLS; n++) begin
			stim[n] = 8'hff;
		end
		$readmemh(STIM_FILE, stim);

		repeat (RST_CYCLES) @(posedge i_clk);
		i_rst <= 1'b0;

		waited = 0;
		@(negedge i_clk);
		while ((o_issue_valid !== 1'b0 || o_full !== 1'b0) && waited < IDLE_TIMEOUT) begin
			@(negedge i_clk);
			waited++;
		end
		if (o_issue_valid !== 1'b0 || o_full !== 1'b0) begin
			$display("timeout: the queue was not idle %0d cycles after reset", IDLE_TIMEOUT);
			timed_out = 1'b1;
		end

		if (!timed_out) begin
			row      = 0;
			cur_test = stim_field(0, C_TEST);
			while (row < MAX_ROWS && stim_field(row, C_TEST) != 8'hff) begin
				if (stim_field(row, C_TEST) != cur_test) begin
					report_test(cur_test);
					cur_test = stim_field(row, C_TEST);
				end
				@(posedge i_clk);
				apply_row(row);
				@(negedge i_clk);
				check_row(row);
				row++;
			end
			if (row > 0) begin
				report_test(cur_test);
			end else begin
				$display("no stimulus rows were found in %s", STIM_FILE);
			end
		end

		$display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, total_errs);
		if (!timed_out && failed == 0 && passed > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/issue_queue.sv ====
// eight-entry compacting issue queue for the integer pipeline, top level of the design
`timescale 1ns/1ns
`default_nettype none

module issue_queue
	import uop_pkg::*, iq_pkg::*;
(
	input  wire                 i_clk,
	input  wire                 i_rst,

	// dispatch from rename
	input  wire                 i_disp_valid,
	input  wire  [OPC_W-1:0]    i_disp_opcode,
	input  wire  [BR_W-1:0]     i_disp_br_mask,
	input  wire  [TAG_W-1:0]    i_disp_rob_tag,
	input  wire  [PREG_W-1:0]   i_disp_rd,
	input  wire  [PREG_W-1:0]   i_disp_rs1,
	input  wire  [PREG_W-1:0]   i_disp_rs2,
	input  wire                 i_disp_p1,
	input  wire                 i_disp_p2,

	// write-back broadcast
	input  wire  [WB_PORTS-1:0] i_wb_valid,
	input  wire  [PREG_W-1:0]   i_wb_preg [WB_PORTS],

	input  wire  [BR_W-1:0]     i_br_kill,

	// registered issue port
	output logic                o_issue_valid,
	output logic [OPC_W-1:0]    o_issue_opcode,
	output logic [TAG_W-1:0]    o_issue_rob_tag,
	output logic [PREG_W-1:0]   o_issue_rd,
	output logic [PREG_W-1:0]   o_issue_rs1,
	output logic [PREG_W-1:0]   o_issue_rs2,

	output logic                o_full
);

	// slot state as seen by the muxes
	wire [OPC_W-1:0]    slot_opcode  [IQ_DEPTH];
	wire [BR_W-1:0]     slot_br_mask [IQ_DEPTH];
	wire [TAG_W-1:0]    slot_rob_tag [IQ_DEPTH];
	wire [PREG_W-1:0]   slot_rd      [IQ_DEPTH];
	wire [PREG_W-1:0]   slot_rs1     [IQ_DEPTH];
	wire [PREG_W-1:0]   slot_rs2     [IQ_DEPTH];
	wire [IQ_DEPTH-1:0] next_val;
	wire [IQ_DEPTH-1:0] next_p1;
	wire [IQ_DEPTH-1:0] next_p2;

	wire [IQ_DEPTH-1:0] request;
	wire [IQ_DEPTH-1:0] grant;
	wire [IQ_IDX_W-1:0] grant_idx;

	wire [IQ_DEPTH-1:0] load;
	wire [IQ_IDX_W-1:0] src_idx [IQ_DEPTH];
	wire [IQ_DEPTH-1:0] disp_sel;
	wire [IQ_CNT_W-1:0] next_count;

	logic [IQ_CNT_W-1:0] occ_count;
	logic                disp_kill;
	logic                disp_accept;
	logic                disp_p1;
	logic                disp_p2;
	logic                grant_kill;

	// no dispatch into a full queue or under a branch being killed
	assign disp_kill   = |(i_disp_br_mask & i_br_kill);
	assign disp_accept = i_disp_valid & ~o_full & ~disp_kill;

	// a write-back in the dispatch cycle still wakes the new entry
	always_comb begin
		disp_p1 = i_disp_p1;
		disp_p2 = i_disp_p2;
		for (int k = 0; k < WB_PORTS; k++) begin
			if (i_wb_valid[k] && (i_wb_preg[k] == i_disp_rs1)) begin
				disp_p1 = 1'b1;
			end
			if (i_wb_valid[k] && (i_wb_preg[k] == i_disp_rs2)) begin
				disp_p2 = 1'b1;
			end
		end
	end

	for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_slot
		wire [IQ_IDX_W-1:0] src = src_idx[i];

		issue_slot u_slot (
			.i_clk      (i_clk),
			.i_rst      (i_rst),
			.i_load     (load[i]),
			.i_opcode   (disp_sel[i] ? i_disp_opcode  : slot_opcode[src]),
			.i_br_mask  (disp_sel[i] ? i_disp_br_mask : slot_br_mask[src]),
			.i_rob_tag  (disp_sel[i] ? i_disp_rob_tag : slot_rob_tag[src]),
			.i_rd       (disp_sel[i] ? i_disp_rd      : slot_rd[src]),
			.i_rs1      (disp_sel[i] ? i_disp_rs1     : slot_rs1[src]),
			.i_rs2      (disp_sel[i] ? i_disp_rs2     : slot_rs2[src]),
			.i_p1       (disp_sel[i] ? disp_p1        : next_p1[src]),
			.i_p2       (disp_sel[i] ? disp_p2        : next_p2[src]),
			.i_wb_valid (i_wb_valid),
			.i_wb_preg  (i_wb_preg),
			.i_br_kill  (i_br_kill),
			.i_grant    (grant[i]),
			.o_request  (request[i]),
			.o_opcode   (slot_opcode[i]),
			.o_br_mask  (slot_br_mask[i]),
			.o_rob_tag  (slot_rob_tag[i]),
			.o_rd       (slot_rd[i]),
			.o_rs1      (slot_rs1[i]),
			.o_rs2      (slot_rs2[i]),
			.o_next_val (next_val[i]),
			.o_next_p1  (next_p1[i]),
			.o_next_p2  (next_p2[i])
		);
	end

	issue_select u_select (
		.i_request   (request),
		.o_grant     (grant),
		.o_grant_idx (grant_idx)
	);

	issue_compact u_compact (
		.i_next_val    (next_val),
		.i_disp_accept (disp_accept),
		.o_load        (load),
		.o_src_idx     (src_idx),
		.o_disp_sel    (disp_sel),
		.o_next_count  (next_count)
	);

	// kill wins over grant
	assign grant_kill = |(slot_br_mask[grant_idx] & i_br_kill);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_issue_valid <= 1'b0;
		end else begin
			o_issue_valid <= |grant & ~grant_kill;
		end
	end

	always_ff @(posedge i_clk) begin
		o_issue_opcode  <= slot_opcode[grant_idx];
		o_issue_rob_tag <= slot_rob_tag[grant_idx];
		o_issue_rd      <= slot_rd[grant_idx];
		o_issue_rs1     <= slot_rs1[grant_idx];
		o_issue_rs2     <= slot_rs2[grant_idx];
	end

	// occupancy tracks the compacted slot count
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			occ_count <= '0;
		end else begin
			occ_count <= next_count;
		end
	end

	assign o_full = (occ_count == IQ_CNT_W'(IQ_DEPTH));

endmodule

`default_nettype wire

// ==== rtl/issue_compact.sv ====
// queue compaction, picks for every slot the old slot or the dispatch port that refills it
`timescale 1ns/1ns
`default_nettype none

module issue_compact
	import iq_pkg::*;
(
	input  wire  [IQ_DEPTH-1:0] i_next_val,
	input  wire                 i_disp_accept,

	output logic [IQ_DEPTH-1:0] o_load,
	output logic [IQ_IDX_W-1:0] o_src_idx [IQ_DEPTH],
	output logic [IQ_DEPTH-1:0] o_disp_sel,
	output logic [IQ_CNT_W-1:0] o_next_count
);

	// rank of each survivor among the survivors below it
	logic [IQ_CNT_W-1:0] rank [IQ_DEPTH];
	logic [IQ_CNT_W-1:0] survivors;
	logic                disp_fits;

	// prefix count over the next-valid bits
	always_comb begin
		survivors = '0;
		for (int j = 0; j < IQ_DEPTH; j++) begin
			rank[j]   = survivors;
			survivors = survivors + IQ_CNT_W'(i_next_val[j]);
		end
	end

	// dispatch lands just above the survivors, if there is room
	assign disp_fits = i_disp_accept && (survivors < IQ_CNT_W'(IQ_DEPTH));

	// slot i takes the survivor of rank i
	// the slot right above the last survivor takes dispatch
	always_comb begin
		for (int i = 0; i < IQ_DEPTH; i++) begin
			o_load[i]     = 1'b0;
			o_src_idx[i]  = '0;
			o_disp_sel[i] = disp_fits && (survivors == IQ_CNT_W'(i));
			for (int j = 0; j < IQ_DEPTH; j++) begin
				if (i_next_val[j] && (rank[j] == IQ_CNT_W'(i))) begin
					o_load[i]    = 1'b1;
					o_src_idx[i] = IQ_IDX_W'(j);
				end
			end
			if (o_disp_sel[i]) begin
				o_load[i] = 1'b1;
			end
		end
	end

	// occupancy after the edge
	assign o_next_count = survivors + IQ_CNT_W'(disp_fits);

endmodule

`default_nettype wire

// ==== rtl/issue_select.sv ====
// fixed-priority issue picker, grants the lowest-index and therefore oldest requesting slot
`timescale 1ns/1ns
`default_nettype none

module issue_select
	import iq_pkg::*;
(
	input  wire  [IQ_DEPTH-1:0] i_request,
	output logic [IQ_DEPTH-1:0] o_grant,
	output logic [IQ_IDX_W-1:0] o_grant_idx
);

	// walk from the top so the lowest requester is the last to write
	always_comb begin
		o_grant     = '0;
		o_grant_idx = '0;
		for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
			if (i_request[i]) begin
				o_grant     = '0;
				o_grant[i]  = 1'b1;
				o_grant_idx = IQ_IDX_W'(i);
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/issue_slot.sv ====
// one issue queue entry with operand wakeup, branch kill and next-state outputs for compaction
`timescale 1ns/1ns
`default_nettype none

module issue_slot
	import uop_pkg::*, iq_pkg::*;
(
	input  wire               i_clk,
	input  wire               i_rst,

	// load word, chosen by the queue from an older slot or dispatch
	input  wire               i_load,
	input  wire  [OPC_W-1:0]  i_opcode,
	input  wire  [BR_W-1:0]   i_br_mask,
	input  wire  [TAG_W-1:0]  i_rob_tag,
	input  wire  [PREG_W-1:0] i_rd,
	input  wire  [PREG_W-1:0] i_rs1,
	input  wire  [PREG_W-1:0] i_rs2,
	input  wire               i_p1,
	input  wire               i_p2,

	// write-back broadcast
	input  wire  [WB_PORTS-1:0] i_wb_valid,
	input  wire  [PREG_W-1:0]   i_wb_preg [WB_PORTS],

	input  wire  [BR_W-1:0]   i_br_kill,
	input  wire               i_grant,

	output logic              o_request,
	output logic [OPC_W-1:0]  o_opcode,
	output logic [BR_W-1:0]   o_br_mask,
	output logic [TAG_W-1:0]  o_rob_tag,
	output logic [PREG_W-1:0] o_rd,
	output logic [PREG_W-1:0] o_rs1,
	output logic [PREG_W-1:0] o_rs2,

	// state this entry carries past the edge, wherever it ends up
	output logic              o_next_val,
	output logic              o_next_p1,
	output logic              o_next_p2
);

	logic val;
	logic p1;
	logic p2;
	logic wake_p1;
	logic wake_p2;
	logic killed;

	// compare both sources against every valid write-back port
	always_comb begin
		wake_p1 = 1'b0;
		wake_p2 = 1'b0;
		for (int k = 0; k < WB_PORTS; k++) begin
			if (i_wb_valid[k] && (i_wb_preg[k] == o_rs1)) begin
				wake_p1 = 1'b1;
			end
			if (i_wb_valid[k] && (i_wb_preg[k] == o_rs2)) begin
				wake_p2 = 1'b1;
			end
		end
	end

	// squashed when any branch we depend on is killed
	assign killed = |(o_br_mask & i_br_kill);

	assign o_request = val & p1 & p2;

	// granted or killed entries do not survive the edge
	assign o_next_val = val & ~killed & ~i_grant;
	assign o_next_p1  = p1 | wake_p1;
	assign o_next_p2  = p2 | wake_p2;

	// without a load the entry has moved elsewhere or left the queue
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			val <= 1'b0;
			p1  <= 1'b0;
			p2  <= 1'b0;
		end else if (i_load) begin
			val <= 1'b1;
			p1  <= i_p1;
			p2  <= i_p2;
		end else begin
			val <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load) begin
			o_opcode  <= i_opcode;
			o_br_mask <= i_br_mask;
			o_rob_tag <= i_rob_tag;
			o_rd      <= i_rd;
			o_rs1     <= i_rs1;
			o_rs2     <= i_rs2;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/iq_pkg.sv ====
// issue queue geometry used by the queue top level and its slot, select and compact blocks
`default_nettype none

package iq_pkg;

	// number of slots, slot index equals age
	localparam int IQ_DEPTH = 8;

	// slot index width
	localparam int IQ_IDX_W = $clog2(IQ_DEPTH);

	// occupancy count, must reach IQ_DEPTH itself
	localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

	// write-back broadcast ports that wake up waiting operands
	localparam int WB_PORTS = 4;

endpackage

`default_nettype wire

// ==== rtl/uop_pkg.sv ====
// micro-op field widths shared by the issue slots, the compactor and the queue top level
`default_nettype none

package uop_pkg;

	// opcode as delivered by rename, kept whole through the queue
	localparam int OPC_W = 7;

	// one mask bit per in-flight branch
	// a micro-op depends on every branch whose bit is set
	localparam int BR_W = 3;

	// reorder buffer tag carried to the issue port
	localparam int TAG_W = 5;

	// physical register number, used for destination and both sources
	localparam int PREG_W = 5;

endpackage

`default_nettype wire
